/* hw/spi_pkg.sv */
// ==============================
// Shared types and sizes of the SPI master
// Mode 0 only, one byte per chip-select cycle
// SCLK_HALF must be 3 or more for the miso sync
// ==============================

package spi_pkg;

    // ==============================
    // Widths that carry a meaning
    // ==============================

    // One byte on the serial link
    typedef logic [7:0] byte_t;

    // Number of the addressed slave
    typedef logic [1:0] cs_sel_t;

    // Active-low selects, one line per slave
    typedef logic [3:0] cs_n_t;

    // Bits sampled so far, 0 to 8
    typedef logic [3:0] bit_cnt_t;

    // Position inside one half period of sclk
    typedef logic [7:0] div_cnt_t;

    // ==============================
    // Sizes
    // ==============================

    // clk cycles per half period of sclk
    localparam div_cnt_t SCLK_HALF = 8'd4;

    // Bits per transfer
    localparam bit_cnt_t BITS_PER_XFER = 4'd8;

    // ==============================
    // Host request
    // ==============================

    // Slave number in the upper bits, payload below
    typedef struct packed {
        cs_sel_t cs_sel;
        byte_t   tx_data;
    } spi_req_t;

endpackage

/* hw/sclk_gen.sv */
// ==============================
// Serial clock source, single clock domain
// sclk is a plain register and idles low
// Ticks are one clk cycle wide
// ==============================

`timescale 1ns/1ps

module sclk_gen (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic sclk,
    output logic rise_tick,
    output logic fall_tick
);

    // Position within the current half period
    spi_pkg::div_cnt_t div_cnt;

    // Last count of a half period
    logic wrap;

    assign wrap = (div_cnt == spi_pkg::div_cnt_t'(spi_pkg::SCLK_HALF - 8'd1));

    // ==============================
    // Divider and edge ticks
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt   <= '0;
            sclk      <= 1'b0;
            rise_tick <= 1'b0;
            fall_tick <= 1'b0;
        end else begin
            // Ticks only last one cycle
            rise_tick <= 1'b0;
            fall_tick <= 1'b0;
            if (!run) begin
                // Idle, hold sclk low and restart the half period
                div_cnt <= '0;
                sclk    <= 1'b0;
            end else if (wrap) begin
                div_cnt <= '0;
                sclk    <= ~sclk;
                // Tick matches the new sclk level
                rise_tick <= ~sclk;
                fall_tick <= sclk;
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

endmodule

/* hw/spi_tx_shift.sv */
// ==============================
// MSB-first transmit shifter
// mosi is the buffer MSB, valid one cycle after load
// Empty bits fill with zero
// ==============================

`timescale 1ns/1ps

module spi_tx_shift (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  spi_pkg::byte_t  tx_data,
    input  logic            shift,
    output logic            mosi
);

    // Outgoing byte, MSB on the wire
    spi_pkg::byte_t tx_buf;

    // ==============================
    // Shift buffer
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Keeps mosi low out of reset
            tx_buf <= '0;
        end else if (load) begin
            // New byte wins over a stray shift
            tx_buf <= tx_data;
        end else if (shift) begin
            // Falling sclk, next lower bit moves up
            tx_buf <= {tx_buf[6:0], 1'b0};
        end
    end

    // ==============================
    // Serial output
    // ==============================

    // First bit is already out before the first rising edge
    assign mosi = tx_buf[7];

endmodule

/* hw/spi_rx_shift.sv */
// ==============================
// Receive shifter with miso synchronizer
// Sample lags miso by two clk cycles
// rx_data is undefined until the first transfer
// ==============================

`timescale 1ns/1ps

module spi_rx_shift (
    input  logic            clk,
    input  logic            rst,
    input  logic            miso,
    input  logic            sample,
    output spi_pkg::byte_t  rx_data
);

    // Two-flop synchronizer stages
    logic miso_meta;
    logic miso_sync;

    // Byte being assembled
    spi_pkg::byte_t rx_buf;

    // ==============================
    // Synchronizer
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            miso_meta <= 1'b0;
            miso_sync <= 1'b0;
        end else begin
            miso_meta <= miso;
            miso_sync <= miso_meta;
        end
    end

    // ==============================
    // Shift register
    // ==============================

    // New bit enters at the LSB
    // first bit of the transfer ends up in bit 7
    always_ff @(posedge clk) begin
        if (sample) begin
            rx_buf <= {rx_buf[6:0], miso_sync};
        end
    end

    // Holds its value between transfers
    assign rx_data = rx_buf;

endmodule

/* hw/spi_ctrl.sv */
// ==============================
// Transfer FSM of the SPI master
// Four-phase req/ack, one byte per request
// req_data must stay stable while req is high
// ==============================

`timescale 1ns/1ps

module spi_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  spi_pkg::spi_req_t req_data,
    output logic              ack,
    input  logic              rise_tick,
    input  logic              fall_tick,
    output logic              run,
    output logic              load,
    output spi_pkg::cs_n_t    cs_n
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        XFER,
        FINISH,
        ACK
    } ctrl_state_e;

    ctrl_state_e state;

    // Rise ticks seen in this transfer
    spi_pkg::bit_cnt_t bit_cnt;

    // Decoded select of the pending request
    spi_pkg::cs_n_t cs_dec;

    // Last bit sampled, wait for the closing fall tick
    logic bits_done;

    assign bits_done = (bit_cnt == spi_pkg::BITS_PER_XFER);

    // ==============================
    // Chip-select decode
    // ==============================

    // One-hot, active low
    always_comb begin
        case (req_data.cs_sel)
            2'd0:    cs_dec = 4'b1110;
            2'd1:    cs_dec = 4'b1101;
            2'd2:    cs_dec = 4'b1011;
            default: cs_dec = 4'b0111;
        endcase
    end

    // ==============================
    // State, counter and select
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
            cs_n    <= '1;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        // Select goes low for the LOAD cycle
                        state <= LOAD;
                        cs_n  <= cs_dec;
                    end
                end
                LOAD: begin
                    // Shifter takes the byte here
                    state   <= XFER;
                    bit_cnt <= '0;
                end
                XFER: begin
                    if (rise_tick) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    // sclk is back low on this tick
                    if (fall_tick && bits_done) begin
                        state <= FINISH;
                        cs_n  <= '1;
                    end
                end
                FINISH: begin
                    state <= ACK;
                end
                ACK: begin
                    // Hold until the host drops req
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Outputs
    // ==============================

    assign load = (state == LOAD);
    assign run  = (state == XFER);
    assign ack  = (state == ACK);

endmodule

/* hw/spi_master_top.sv */
// ==============================
// SPI master, mode 0, four slaves
// Host side is a four-phase req/ack handshake
// miso is synchronized inside
// ==============================

`timescale 1ns/1ps

module spi_master_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  spi_pkg::spi_req_t req_data,
    output logic              ack,
    output spi_pkg::byte_t    rx_data,
    output logic              sclk,
    output logic              mosi,
    output spi_pkg::cs_n_t    cs_n,
    input  logic              miso
);

    // Divider enable from the FSM
    logic run;
    // Edge ticks of sclk
    logic rise_tick;
    logic fall_tick;
    // Byte load into the transmit shifter
    logic load;

    sclk_gen u_sclk_gen (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .sclk      (sclk),
        .rise_tick (rise_tick),
        .fall_tick (fall_tick)
    );

    // Transmit side advances on falling sclk
    spi_tx_shift u_tx_shift (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .tx_data (req_data.tx_data),
        .shift   (fall_tick),
        .mosi    (mosi)
    );

    // Receive side samples on rising sclk
    spi_rx_shift u_rx_shift (
        .clk     (clk),
        .rst     (rst),
        .miso    (miso),
        .sample  (rise_tick),
        .rx_data (rx_data)
    );

    spi_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rise_tick (rise_tick),
        .fall_tick (fall_tick),
        .run       (run),
        .load      (load),
        .cs_n      (cs_n)
    );

endmodule

/* testbench/spi_master_tb.sv */
// ==============================
// Testbench for the SPI master
// Run from the project root, reads testbench/spi_testdata.txt
// Slave model answers in mode 0 on any of the four selects
// ==============================

`timescale 1ns/1ps

module spi_master_tb;

    // Limit for each handshake wait, in clk cycles
    localparam int WAIT_LIMIT = 40 * spi_pkg::SCLK_HALF;

    logic              clk;
    logic              rst;
    logic              req;
    spi_pkg::spi_req_t req_data;
    logic              ack;
    spi_pkg::byte_t    rx_data;
    logic              sclk;
    logic              mosi;
    spi_pkg::cs_n_t    cs_n;
    logic              miso;

    // Slave model state
    spi_pkg::byte_t slave_reply;
    spi_pkg::byte_t slave_cap;
    int             slave_pos;
    int             rise_count;
    logic           sclk_prev;
    spi_pkg::cs_n_t cs_prev;
    // Select line expected for the running request
    spi_pkg::cs_n_t exp_cs;
    logic           ack_prev;
    // req and cs_n at the previous falling clk edge
    logic           req_prev;
    spi_pkg::cs_n_t cs_mid_prev;
    int             errors;
    int             timeouts;

    spi_master_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rx_data  (rx_data),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n),
        .miso     (miso)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    // ==============================
    // Slave model, mode 0
    // ==============================

    always @(posedge clk) begin
        #1;
        if (!rst) begin
            // Select just fell, first reply bit out
            if (cs_prev == 4'hf && cs_n != 4'hf) begin
                miso = slave_reply[7];
                slave_pos = 1;
            end
            // Rising sclk, take mosi
            if (sclk && !sclk_prev) begin
                rise_count++;
                slave_cap = {slave_cap[6:0], mosi};
                if (cs_n !== exp_cs) begin
                    report_mismatch("chip select at sclk rise", exp_cs, cs_n);
                end
            end
            // Falling sclk, next reply bit
            if (!sclk && sclk_prev && slave_pos < 8) begin
                miso = slave_reply[7 - slave_pos];
                slave_pos++;
            end
        end
        sclk_prev = sclk;
        cs_prev   = cs_n;
    end

    // Handshake and select watch, mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            // req as it stood at the clk edge where ack rose
            if (ack && !ack_prev && !req_prev) begin
                report_problem("ack rose while req was low");
            end
            // Selects already released in the cycle before ack
            if (ack && !ack_prev && cs_mid_prev !== 4'hf) begin
                report_mismatch("select release before ack", 4'hf, cs_mid_prev);
            end
            if (cs_n != 4'hf && cs_n != exp_cs) begin
                report_mismatch("chip select", exp_cs, cs_n);
            end
        end
        ack_prev    = ack;
        req_prev    = req;
        cs_mid_prev = cs_n;
    end

    // ==============================
    // Host driver
    // ==============================

    task automatic run_transfer(input int n, input spi_pkg::cs_sel_t sel,
                                input spi_pkg::byte_t tx, input spi_pkg::byte_t reply,
                                output bit done);
        int    wait_cnt;
        int    gap;
        string tag;
        done = 1'b0;
        tag  = $sformatf(" #%0d", n);
        gap  = $urandom % 6;
        repeat (gap) @(posedge clk);
        slave_reply = reply;
        slave_cap   = '0;
        rise_count  = 0;
        exp_cs      = ~(spi_pkg::cs_n_t'(1) << sel);
        @(posedge clk);
        #1;
        req_data.cs_sel  = sel;
        req_data.tx_data = tx;
        req = 1'b1;
        wait_cnt = 0;
        while (!ack && wait_cnt < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (!ack) begin
            timeouts++;
            $display("Timeout: no ack for transfer%s", tag);
        end else begin
            if (rx_data !== reply) report_mismatch({"receive", tag}, reply, rx_data);
            if (slave_cap !== tx) report_mismatch({"transmit", tag}, tx, slave_cap);
            if (rise_count != 8) report_mismatch({"sclk rises", tag}, 8, rise_count);
            if (cs_n !== 4'hf) report_mismatch({"select release", tag}, 4'hf, cs_n);
            req = 1'b0;
            wait_cnt = 0;
            while (ack && wait_cnt < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                wait_cnt++;
            end
            if (ack) begin
                timeouts++;
                $display("Timeout: ack stayed high after req fell, transfer%s", tag);
            end else begin
                done = 1'b1;
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int          fd;
        int          n;
        int          fields;
        string       line;
        logic [31:0] sel_v;
        logic [31:0] tx_v;
        logic [31:0] rep_v;
        bit          done;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        req_data = '0;
        miso = 1'b0;
        slave_reply = '0;
        slave_cap = '0;
        slave_pos = 8;
        rise_count = 0;
        sclk_prev = 1'b0;
        cs_prev = '1;
        exp_cs = '1;
        ack_prev = 1'b0;
        req_prev = 1'b0;
        cs_mid_prev = '1;
        errors = 0;
        timeouts = 0;
        n = 0;
        void'($urandom(32'h0b62_1409));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        // Idle state out of reset
        if (ack !== 1'b0) report_mismatch("reset ack", 0, ack);
        if (sclk !== 1'b0) report_mismatch("reset sclk", 0, sclk);
        if (cs_n !== 4'hf) report_mismatch("reset cs_n", 4'hf, cs_n);
        fd = $fopen("testbench/spi_testdata.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open testbench/spi_testdata.txt");
        end else begin
            done = 1'b1;
            while (done && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 2 && line.substr(0, 1) != "//") begin
                    fields = $sscanf(line, "%h %h %h", sel_v, tx_v, rep_v);
                    if (fields == 3) begin
                        run_transfer(n, sel_v[1:0], tx_v[7:0], rep_v[7:0], done);
                        n++;
                    end else begin
                        report_problem({"unreadable data line: ", line});
                    end
                end
            end
            $fclose(fd);
            if (n == 0) report_problem("no transfers found in the data file");
        end
        repeat (2) @(posedge clk);
        $display("Transfers: %0d, errors: %0d, timeouts: %0d", n, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* testbench/spi_testdata.txt */
// Columns: slave number, byte sent on mosi, slave reply on miso (all hex)
// One transfer per line, run in order
0 a5 3c
1 5a c3
2 00 ff
3 ff 00
0 80 01
1 01 80
2 55 aa
3 aa 55
0 12 34
1 fe 7f
2 c9 96
3 3e e3
0 7e 81
2 69 b4

/* sim.f */
hw/spi_pkg.sv
hw/sclk_gen.sv
hw/spi_tx_shift.sv
hw/spi_rx_shift.sv
hw/spi_ctrl.sv
hw/spi_master_top.sv
testbench/spi_master_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator, run from the project root
verilator --binary --timing -Wno-fatal -f sim.f --top-module spi_master_tb \
    -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vspi_master_tb > sim.log 2>&1 \
    && grep -qF '*** PASSED ***' sim.log \
    && echo "Simulation passed, see sim.log" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
